// ==== list.f ====
+incdir+logic
logic/evb_pkg.sv
logic/evb_fsm.sv
logic/evb_beat_counter.sv
logic/evb_line_buffer.sv
logic/evb_msg_encode.sv
logic/evb_entry_top.sv
bench/evb_entry_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the eviction buffer entry testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module evb_entry_tb -o evb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/evb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

// ==== bench/evb_entry_tb.sv ====
// expects the DUT to finish each job within 300 cycles; req_ready is held high throughout.
`timescale 1ns/1ps

module evb_entry_tb;

    import evb_pkg::*;

    typedef struct {
        evb_func_t       func;
        evb_probe_t      pfn;
        evb_line_state_t st;
        logic            spec;
        logic [1:0]      act; // 1 commit, 2 kill, 3 merge.
        evb_addr_t       addr;
        evb_addr_t       cmp;
        evb_opcode_t     op;
        evb_param_t      par;
        int              beats; // zero when the job is killed.
        evb_mesi_t       mesi;
        logic            rdata;
        logic            hit;
        evb_way_t        cft;
        logic            derr;
    } row_t;

    logic dcu_clk, dcu_reset_n, enq_valid, enq_spec, mrg_valid, cmt_valid, cmt_kill;
    evb_addr_t enq_addr, cmp_addr, req_addr, c_addr;
    evb_way_t enq_way, cmp_cft, req_way;
    evb_line_state_t enq_state;
    evb_func_t enq_func;
    evb_probe_t probe_func;
    evb_source_t enq_source, c_source;
    logic req_ready, ack_valid, c_ready, d_valid, d_error;
    evb_data_t ack_rdata, c_data;
    logic valid, cmp_hit, cmp_speculative, req_valid, req_lock, req_data, req_last;
    evb_mesi_t req_mesi;
    logic c_valid, c_last, d_ready, bus_fault;
    evb_opcode_t c_opcode;
    evb_param_t c_param;

    row_t      jobs[$];
    row_t      cur;
    evb_source_t cur_source;
    evb_data_t line_data[$];
    logic [31:0] rng = 32'd44314;
    int req_count, c_count, d_count, fault_count, fail_count;
    logic ack_due, d_due;

    evb_entry_top evb_entry_top_inst (.*);

    initial begin
        dcu_clk = 1'b0;
        forever #50 dcu_clk = ~dcu_clk;
    end

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic stop_run();
        fail_count++;
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic stop_with(input string msg);
        $display("%0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_opcode(input string name, input evb_opcode_t got, input evb_opcode_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_param(input string name, input evb_param_t got, input evb_param_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_data(input string name, input evb_data_t got, input evb_data_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_mesi(input string name, input evb_mesi_t got, input evb_mesi_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_way(input string name, input evb_way_t got, input evb_way_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input evb_addr_t got, input evb_addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_source(input string name, input evb_source_t got, input evb_source_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic add_job(input evb_func_t f, input evb_probe_t p, input evb_line_state_t s,
                           input logic sp, input logic [1:0] a, input evb_addr_t ad,
                           input evb_addr_t cm, input evb_opcode_t o, input evb_param_t pa,
                           input int b, input evb_mesi_t m, input logic rd, input logic h,
                           input evb_way_t cf, input logic de);
        row_t r;
        r.func = f;
        r.pfn = p;
        r.st = s;
        r.spec = sp;
        r.act = a;
        r.addr = ad;
        r.cmp = cm;
        r.op = o;
        r.par = pa;
        r.beats = b;
        r.mesi = m;
        r.rdata = rd;
        r.hit = h;
        r.cft = cf;
        r.derr = de;
        jobs.push_back(r);
    endtask

    // request, C and fault monitor.
    always @(negedge dcu_clk) begin
        ack_due = 1'b0;
        d_due = 1'b0;
        if (dcu_reset_n) begin
            if (req_valid && req_ready) begin
                check_addr("req_addr", req_addr, cur.addr + evb_addr_t'(req_count * 16));
                check_way("req_way", req_way, 4'b0010);
                check_mesi("req_mesi", req_mesi, cur.mesi);
                // lock stays only with a request that keeps the line.
                check_bit("req_lock", req_lock, cur.st[L_BIT] & cur.mesi[S_BIT]);
                check_bit("req_data", req_data, cur.rdata);
                check_bit("req_last", req_last, req_count == cur.beats - 1);
                req_count++;
                ack_due = req_data;
            end
            if (c_valid && c_ready) begin
                check_opcode("c_opcode", c_opcode, cur.op);
                check_param("c_param", c_param, cur.par);
                check_addr("c_addr", c_addr, cur.addr);
                check_source("c_source", c_source, cur_source);
                check_bit("c_last", c_last, c_count == cur.beats - 1);
                if (cur.beats == 4) begin
                    check_data("c_data", c_data, line_data[c_count]);
                end
                c_count++;
                d_due = c_last & ~cur.func[5]; // releases wait for a grant.
            end
            if (d_valid) begin
                check_bit("d_ready", d_ready, 1'b1);
            end
            if (bus_fault) begin
                fault_count++;
            end
        end
    end

    // cache array, C stall and D responders.
    always @(posedge dcu_clk) begin
        ack_valid <= ack_due;
        if (ack_due) begin
            evb_data_t d;
            d = {xorshift32(), xorshift32(), xorshift32(), xorshift32()};
            ack_rdata <= d;
            line_data.push_back(d);
        end
        d_valid <= d_due;
        d_error <= d_due & cur.derr;
        if (d_due) begin
            d_count++;
        end
        c_ready <= (xorshift32() & 32'h3) != 32'h0;
    end

    task automatic wait_idle();
        int n;
        for (n = 0; n < 300; n++) begin
            @(negedge dcu_clk);
            if (!valid) begin
                break;
            end
        end
        if (valid) begin
            stop_with("timeout: entry never returned to invalid");
        end
    endtask

    task automatic run_job(input row_t r, input int idx);
        int exp_d;
        cur = r;
        cur_source = evb_source_t'(idx);
        req_count = 0;
        c_count = 0;
        d_count = 0;
        fault_count = 0;
        line_data.delete();
        @(posedge dcu_clk);
        enq_valid <= 1'b1;
        enq_spec <= r.spec;
        enq_addr <= r.addr;
        enq_way <= 4'b0010;
        enq_state <= r.st;
        enq_func <= r.func;
        probe_func <= r.pfn;
        enq_source <= cur_source;
        cmp_addr <= r.cmp;
        @(posedge dcu_clk);
        enq_valid <= 1'b0;
        @(negedge dcu_clk);
        check_bit("valid", valid, 1'b1);
        check_bit("cmp_speculative", cmp_speculative, r.spec);
        check_bit("cmp_hit", cmp_hit, r.hit);
        check_way("cmp_cft", cmp_cft, r.cft);
        if (r.spec) begin
            @(posedge dcu_clk);
            cmt_valid <= (r.act == 2'd1) || (r.act == 2'd2);
            cmt_kill <= (r.act == 2'd2);
            mrg_valid <= (r.act == 2'd3);
            @(posedge dcu_clk);
            cmt_valid <= 1'b0;
            cmt_kill <= 1'b0;
            mrg_valid <= 1'b0;
        end
        wait_idle();
        repeat (2) @(negedge dcu_clk);
        exp_d = (r.beats != 0 && !r.func[5]) ? 1 : 0;
        check_count("request count", req_count, r.beats);
        check_count("C beat count", c_count, r.beats);
        check_count("D beat count", d_count, exp_d);
        check_count("bus_fault pulses", fault_count, exp_d * int'(r.derr));
        check_bit("cmp_hit idle", cmp_hit, 1'b0);
        check_way("cmp_cft idle", cmp_cft, 4'b0000);
    endtask

    initial begin
        dcu_reset_n = 1'b0;
        enq_valid = 1'b0;
        enq_spec = 1'b0;
        enq_addr = '0;
        enq_way = '0;
        enq_state = '0;
        enq_func = '0;
        probe_func = '0;
        enq_source = '0;
        mrg_valid = 1'b0;
        cmt_valid = 1'b0;
        cmt_kill = 1'b0;
        cmp_addr = '0;
        req_ready = 1'b1;
        ack_valid = 1'b0;
        ack_rdata = '0;
        c_ready = 1'b0;
        d_valid = 1'b0;
        d_error = 1'b0;
        ack_due = 1'b0;
        d_due = 1'b0;
        fail_count = 0;
        // func, probe, state, spec, act, addr, cmp, op, param, beats, mesi, rdata, hit, cft, derr
        add_job(6'h01, 4'h0, 4'h6, 0, 0, 32'h0001_2340, 32'h0001_2348, 7, 3, 4, 3'b011, 1, 1, 4'hf, 0);
        add_job(6'h02, 4'h0, 4'h4, 0, 0, 32'h0002_4780, 32'h0002_6780, 7, 2, 4, 3'b000, 1, 0, 4'hf, 1);
        add_job(6'h04, 4'h0, 4'h2, 0, 0, 32'h0003_0100, 32'h0003_0140, 6, 1, 1, 3'b000, 0, 0, 4'h0, 0);
        add_job(6'h0c, 4'h0, 4'h1, 0, 0, 32'h0004_1200, 32'h0004_1208, 6, 2, 1, 3'b000, 0, 1, 4'h2, 0);
        add_job(6'h11, 4'h0, 4'h1, 0, 0, 32'h0005_0a40, 32'h0005_2a40, 6, 3, 1, 3'b011, 0, 0, 4'h2, 1);
        add_job(6'h20, 4'h4, 4'h6, 0, 0, 32'h0006_0040, 32'h0006_0080, 4, 3, 1, 3'b011, 1, 0, 4'h0, 0);
        add_job(6'h20, 4'hc, 4'h6, 0, 0, 32'h0007_1fc0, 32'h0007_1fc4, 5, 3, 4, 3'b011, 1, 1, 4'hf, 0);
        add_job(6'h20, 4'h2, 4'h2, 0, 0, 32'h0008_0800, 32'h0008_2800, 4, 0, 1, 3'b001, 0, 0, 4'hf, 0);
        add_job(6'h20, 4'ha, 4'h4, 0, 0, 32'h0009_0e00, 32'h0009_0e40, 5, 5, 4, 3'b001, 1, 0, 4'h0, 0);
        add_job(6'h20, 4'h1, 4'h1, 0, 0, 32'h000a_0600, 32'h000a_0630, 4, 2, 1, 3'b000, 0, 1, 4'h2, 0);
        add_job(6'h20, 4'h9, 4'h1, 0, 0, 32'h000b_1000, 32'h000b_3000, 4, 2, 1, 3'b000, 0, 0, 4'h2, 0);
        add_job(6'h20, 4'h9, 4'h6, 0, 0, 32'h000c_0c40, 32'h000c_0c80, 5, 1, 4, 3'b000, 1, 0, 4'h0, 0);
        add_job(6'h01, 4'h0, 4'h1, 1, 1, 32'h000d_0200, 32'h000d_0208, 6, 3, 1, 3'b011, 0, 1, 4'h2, 0);
        add_job(6'h01, 4'h0, 4'h2, 1, 1, 32'h000e_0280, 32'h000e_2280, 0, 0, 0, 3'b000, 0, 0, 4'hf, 0);
        add_job(6'h04, 4'h0, 4'h1, 1, 2, 32'h000f_0300, 32'h000f_0340, 0, 0, 0, 3'b000, 0, 0, 4'h0, 0);
        add_job(6'h01, 4'h0, 4'h6, 1, 3, 32'h0010_0380, 32'h0010_0384, 7, 3, 4, 3'b011, 1, 1, 4'hf, 1);
        add_job(6'h01, 4'h0, 4'he, 0, 0, 32'h0011_0400, 32'h0011_0440, 7, 3, 4, 3'b011, 1, 0, 4'h0, 0);
        add_job(6'h20, 4'h1, 4'h9, 0, 0, 32'h0012_0480, 32'h0012_0480, 4, 2, 1, 3'b000, 0, 1, 4'h2, 0);
        repeat (8) @(posedge dcu_clk);
        dcu_reset_n <= 1'b1;
        @(negedge dcu_clk);
        check_bit("valid after reset", valid, 1'b0);
        check_bit("cmp_hit after reset", cmp_hit, 1'b0);
        check_way("cmp_cft after reset", cmp_cft, 4'b0000);
        check_bit("bus_fault after reset", bus_fault, 1'b0);
        foreach (jobs[i]) begin
            run_job(jobs[i], i);
        end
        if (fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1);
        end
    end

endmodule

// ==== logic/evb_entry_top.sv ====
// one eviction buffer entry; d_ready is always high and ack data must come one cycle after grant.
`timescale 1ns/1ps
`include "evb_consts.svh"

module evb_entry_top (
    input  logic                     dcu_clk,
    input  logic                     dcu_reset_n,
    input  logic                     enq_valid,
    input  logic                     enq_spec,
    input  evb_pkg::evb_addr_t       enq_addr,
    input  evb_pkg::evb_way_t        enq_way,
    input  evb_pkg::evb_line_state_t enq_state,
    input  evb_pkg::evb_func_t       enq_func,
    input  evb_pkg::evb_probe_t      probe_func,
    input  evb_pkg::evb_source_t     enq_source,
    input  logic                     mrg_valid,
    input  logic                     cmt_valid,
    input  logic                     cmt_kill,
    input  evb_pkg::evb_addr_t       cmp_addr,
    input  logic                     req_ready,
    input  logic                     ack_valid,
    input  evb_pkg::evb_data_t       ack_rdata,
    input  logic                     c_ready,
    input  logic                     d_valid,
    input  logic                     d_error,
    output logic                     valid,
    output logic                     cmp_hit,
    output logic                     cmp_speculative,
    output evb_pkg::evb_way_t        cmp_cft,
    output logic                     req_valid,
    output evb_pkg::evb_addr_t       req_addr,
    output evb_pkg::evb_way_t        req_way,
    output evb_pkg::evb_mesi_t       req_mesi,
    output logic                     req_lock,
    output logic                     req_data,
    output logic                     req_last,
    output logic                     c_valid,
    output evb_pkg::evb_opcode_t     c_opcode,
    output evb_pkg::evb_param_t      c_param,
    output evb_pkg::evb_addr_t       c_addr,
    output evb_pkg::evb_data_t       c_data,
    output evb_pkg::evb_source_t     c_source,
    output logic                     c_last,
    output logic                     d_ready,
    output logic                     bus_fault
);

    import evb_pkg::*;

    evb_fsm_e        fsm_state;
    evb_addr_t       addr;
    evb_way_t        way;
    evb_func_t       func;
    evb_line_state_t line_state;
    evb_beat_t       req_beat;
    evb_beat_t       wr_beat;
    evb_beat_t       rd_beat;
    logic            init_en;
    logic            func_en;
    logic            state_en;
    logic            dequeue;
    logic            release_probe_done;
    logic            probe_nodata;
    logic            req_last_raw;
    logic            c_last_raw;
    logic            req_beat_last;
    logic            wr_beat_last;
    logic            rd_beat_last;
    logic            req_grant;
    logic            c_grant;
    logic            ack_wr;
    logic            same_tag;
    logic            same_index;

    always_ff @(posedge dcu_clk) begin
        if (init_en) begin
            addr <= enq_addr;
            way  <= enq_way;
        end
    end

    always_ff @(posedge dcu_clk or negedge dcu_reset_n) begin
        if (!dcu_reset_n) begin
            bus_fault <= 1'b0;
        end else begin
            bus_fault <= d_valid & d_ready & d_error;
        end
    end

    assign valid           = (fsm_state != INVALID);
    assign cmp_speculative = (fsm_state == SPECULATIVE);
    assign same_tag   = (cmp_addr[`EVB_PALEN-1:`EVB_IDX_MSB+1] == addr[`EVB_PALEN-1:`EVB_IDX_MSB+1]);
    assign same_index = (cmp_addr[`EVB_IDX_MSB:`EVB_IDX_LSB] == addr[`EVB_IDX_MSB:`EVB_IDX_LSB]);
    assign cmp_hit    = valid & same_tag & same_index;
    assign cmp_cft    = {4{valid & same_index}} & (way | {4{~line_state[S_BIT]}}); // owned blocks all.

    assign req_valid = (fsm_state == COMMITTED);
    assign req_grant = req_valid & req_ready;
    assign req_addr  = {addr[`EVB_PALEN-1:`EVB_IDX_LSB], req_beat, 4'd0};
    assign req_way   = way;
    assign req_last  = req_beat_last | req_last_raw;

    assign ack_wr = ack_valid & req_data;

    assign c_valid = (fsm_state == RELEASE);
    assign c_grant = c_valid & c_ready;
    assign c_addr  = {addr[`EVB_PALEN-1:`EVB_IDX_LSB], {`EVB_IDX_LSB{1'b0}}};
    assign c_last  = rd_beat_last | c_last_raw;
    assign d_ready = 1'b1;

    assign probe_nodata       = func[5] & req_last_raw;
    assign release_probe_done = dequeue & c_valid & func[5];
    assign state_en           = func_en | release_probe_done;

    evb_fsm u_fsm (
        .dcu_clk(dcu_clk), .dcu_reset_n(dcu_reset_n),
        .enq_valid(enq_valid), .enq_spec(enq_spec), .mrg_valid(mrg_valid),
        .cmt_valid(cmt_valid), .cmt_kill(cmt_kill), .line_shared(line_state[S_BIT]),
        .func_probe(func[5]), .probe_nodata(probe_nodata),
        .req_ready(req_ready), .req_last(req_last), .c_ready(c_ready), .c_last(c_last),
        .d_valid(d_valid), .fsm_state(fsm_state), .init_en(init_en), .func_en(func_en),
        .dequeue(dequeue)
    );

    evb_beat_counter req_cnt (
        .dcu_clk(dcu_clk), .dcu_reset_n(dcu_reset_n), .clear(init_en),
        .step(req_grant), .beat(req_beat), .last(req_beat_last)
    );

    evb_beat_counter wr_cnt (
        .dcu_clk(dcu_clk), .dcu_reset_n(dcu_reset_n), .clear(init_en),
        .step(ack_wr), .beat(wr_beat), .last(wr_beat_last)
    );

    evb_beat_counter rd_cnt (
        .dcu_clk(dcu_clk), .dcu_reset_n(dcu_reset_n), .clear(init_en),
        .step(c_grant), .beat(rd_beat), .last(rd_beat_last)
    );

    evb_line_buffer u_line_buffer (
        .dcu_clk(dcu_clk), .wr_en(ack_wr), .wr_beat(wr_beat), .wr_data(ack_rdata),
        .rd_beat(rd_beat), .rd_data(c_data)
    );

    evb_msg_encode u_msg_encode (
        .dcu_clk(dcu_clk), .func_en(func_en), .state_en(state_en),
        .release_probe_done(release_probe_done), .enq_func(enq_func),
        .probe_func(probe_func), .enq_state(enq_state), .enq_source(enq_source),
        .func(func), .line_state(line_state), .req_mesi(req_mesi), .req_lock(req_lock),
        .req_data(req_data), .req_last_raw(req_last_raw), .c_opcode(c_opcode),
        .c_param(c_param), .c_source(c_source), .c_last_raw(c_last_raw)
    );

    // last beat lands one cycle after the final grant, so the line is complete in RELEASE.
    a_last_ack_in_release: assert property (
        @(posedge dcu_clk) disable iff (!dcu_reset_n)
        (ack_wr && wr_beat_last) |-> (fsm_state == RELEASE)
    );

endmodule

// ==== logic/evb_msg_encode.sv ====
// job and line state registers; func and probe_func are trusted to be one-hot.
`timescale 1ns/1ps

module evb_msg_encode (
    input  logic                     dcu_clk,
    input  logic                     func_en,
    input  logic                     state_en,
    input  logic                     release_probe_done,
    input  evb_pkg::evb_func_t       enq_func,
    input  evb_pkg::evb_probe_t      probe_func,
    input  evb_pkg::evb_line_state_t enq_state,
    input  evb_pkg::evb_source_t     enq_source,
    output evb_pkg::evb_func_t       func,
    output evb_pkg::evb_line_state_t line_state,
    output evb_pkg::evb_mesi_t       req_mesi,
    output logic                     req_lock,
    output logic                     req_data,
    output logic                     req_last_raw,
    output evb_pkg::evb_opcode_t     c_opcode,
    output evb_pkg::evb_param_t      c_param,
    output evb_pkg::evb_source_t     c_source,
    output logic                     c_last_raw
);

    import evb_pkg::*;

    evb_probe_t      probefn;
    evb_line_state_t cap_state;
    evb_line_state_t state_nx;
    evb_param_t      param_rel;
    evb_param_t      param_probe;
    logic            fn_wb;
    logic            fn_wbinval;
    logic            fn_inval;
    logic            fn_probe;
    logic            pf_ton;
    logic            pf_tob;
    logic            pf_tot;
    logic            pf_block;
    logic            st_s;
    logic            st_e;
    logic            st_m;
    logic            no_data;

    always_ff @(posedge dcu_clk) begin
        if (func_en) begin
            func     <= enq_func;
            probefn  <= probe_func;
            c_source <= enq_source;
        end
    end

    always_ff @(posedge dcu_clk) begin
        if (state_en) begin
            line_state <= state_nx;
        end
    end

    assign fn_wb      = func[0];
    assign fn_wbinval = func[1];
    assign fn_inval   = func[2];
    assign fn_probe   = func[5];
    assign pf_ton     = probefn[0];
    assign pf_tob     = probefn[1];
    assign pf_tot     = probefn[2];
    assign pf_block   = probefn[3];
    assign st_s       = line_state[S_BIT];
    assign st_e       = line_state[E_BIT];
    assign st_m       = line_state[M_BIT];

    // state left behind by a probe.
    assign cap_state[M_BIT] = 1'b0;
    assign cap_state[E_BIT] = st_e & pf_tot;
    assign cap_state[S_BIT] = st_s & (pf_tot | pf_tob);
    assign cap_state[L_BIT] = line_state[L_BIT];
    assign state_nx = release_probe_done ? cap_state : enq_state;

    assign req_mesi = fn_probe ? {1'b0, pf_tot & st_e, pf_tob | pf_tot} : {1'b0, fn_wb, fn_wb};
    assign req_lock = line_state[L_BIT] & (fn_probe ? (pf_tob | pf_tot) : fn_wb);
    assign req_data = st_m & ~fn_inval;

    // single request and single beat.
    assign no_data      = fn_inval | ~st_m | (fn_probe & ~pf_block);
    assign req_last_raw = no_data;
    assign c_last_raw   = no_data;

    assign c_opcode = ({3{fn_inval}} & 3'd6) |
                      ({3{fn_wb | fn_wbinval}} & (st_m ? 3'd7 : 3'd6)) |
                      ({3{fn_probe}} & ((pf_block & st_m) ? 3'd5 : 3'd4));

    assign param_rel   = st_e ? 3'd1 : 3'd2;
    assign param_probe = ({3{pf_tot}} & (st_e ? 3'd3 : st_s ? 3'd4 : 3'd5)) |
                         ({3{pf_tob}} & (st_e ? 3'd0 : st_s ? 3'd4 : 3'd5)) |
                         ({3{pf_ton}} & (st_e ? 3'd1 : st_s ? 3'd2 : 3'd5));

    assign c_param = ({3{fn_inval | fn_wbinval}} & param_rel) |
                     ({3{fn_wb}} & 3'd3) |
                     ({3{fn_probe}} & param_probe);

endmodule

// ==== logic/evb_line_buffer.sv ====
// holds one line; a beat read before its write returns stale data.
`timescale 1ns/1ps
`include "evb_consts.svh"

module evb_line_buffer (
    input  logic               dcu_clk,
    input  logic               wr_en,
    input  evb_pkg::evb_beat_t wr_beat,
    input  evb_pkg::evb_data_t wr_data,
    input  evb_pkg::evb_beat_t rd_beat,
    output evb_pkg::evb_data_t rd_data
);

    import evb_pkg::*;

    evb_data_t mem [`EVB_BEATS];

    // cache array return.
    always_ff @(posedge dcu_clk) begin
        if (wr_en) begin
            mem[wr_beat] <= wr_data;
        end
    end

    assign rd_data = mem[rd_beat]; // feeds c_data directly.

endmodule

// ==== logic/evb_beat_counter.sv ====
// wraps after the last beat of a line; clear and step must never come in the same cycle.
`timescale 1ns/1ps
`include "evb_consts.svh"

module evb_beat_counter (
    input  logic               dcu_clk,
    input  logic               dcu_reset_n,
    input  logic               clear,
    input  logic               step,
    output evb_pkg::evb_beat_t beat,
    output logic               last
);

    import evb_pkg::*;

    always_ff @(posedge dcu_clk or negedge dcu_reset_n) begin
        if (!dcu_reset_n) begin
            beat <= '0;
        end else if (clear) begin
            beat <= '0;
        end else if (step) begin
            beat <= beat + 1'b1; // wraps at line end.
        end
    end

    assign last = (beat == evb_beat_t'(`EVB_BEATS - 1));

    // a new job arrives only on an idle entry.
    a_no_clear_step: assert property (
        @(posedge dcu_clk) disable iff (!dcu_reset_n)
        !(clear && step)
    );

endmodule

// ==== logic/evb_fsm.sv ====
// entry life cycle; a probe returns to INVALID right after its C message, never to SPECULATIVE.
`timescale 1ns/1ps

module evb_fsm (
    input  logic               dcu_clk,
    input  logic               dcu_reset_n,
    input  logic               enq_valid,
    input  logic               enq_spec,
    input  logic               mrg_valid,
    input  logic               cmt_valid,
    input  logic               cmt_kill,
    input  logic               line_shared,
    input  logic               func_probe,
    input  logic               probe_nodata,
    input  logic               req_ready,
    input  logic               req_last,
    input  logic               c_ready,
    input  logic               c_last,
    input  logic               d_valid,
    output evb_pkg::evb_fsm_e  fsm_state,
    output logic               init_en,
    output logic               func_en,
    output logic               dequeue
);

    import evb_pkg::*;

    evb_fsm_e fsm_ns;
    logic     c_done;

    assign c_done = (fsm_state == RELEASE) & c_ready & c_last;

    always_ff @(posedge dcu_clk or negedge dcu_reset_n) begin
        if (!dcu_reset_n) begin
            fsm_state <= INVALID;
        end else begin
            fsm_state <= fsm_ns;
        end
    end

    always_comb begin
        fsm_ns = fsm_state;
        case (fsm_state)
            INVALID: begin
                if (enq_valid) begin
                    if (!enq_spec) begin
                        fsm_ns = COMMITTED;
                    end else if (!cmt_valid) begin
                        fsm_ns = SPECULATIVE; // wait for the commit.
                    end else if (cmt_kill) begin
                        fsm_ns = KILLED;
                    end else begin
                        fsm_ns = COMMITTED;
                    end
                end
            end
            SPECULATIVE: begin
                if (mrg_valid) begin
                    fsm_ns = COMMITTED; // merge confirms.
                end else if (cmt_valid) begin
                    if (cmt_kill || !line_shared) begin
                        fsm_ns = KILLED;
                    end else begin
                        fsm_ns = COMMITTED;
                    end
                end
            end
            COMMITTED: begin
                // no-data probes leave on the first request.
                if (req_ready && (probe_nodata || req_last)) begin
                    fsm_ns = RELEASE;
                end
            end
            RELEASE: begin
                if (c_done) begin
                    fsm_ns = INFLIGHT;
                end
            end
            INFLIGHT: begin
                // probes need no grant.
                if (func_probe || d_valid) begin
                    fsm_ns = INVALID;
                end
            end
            KILLED: begin
                fsm_ns = INVALID;
            end
            default: begin
                fsm_ns = INVALID;
            end
        endcase
    end

    assign init_en = enq_valid & (fsm_state == INVALID);
    assign func_en = init_en | (mrg_valid & (fsm_state == SPECULATIVE));
    assign dequeue = c_done | (fsm_state == KILLED);

    a_state_legal: assert property (
        @(posedge dcu_clk) disable iff (!dcu_reset_n)
        !$isunknown(fsm_state) &&
        (fsm_state inside {INVALID, SPECULATIVE, COMMITTED, RELEASE, INFLIGHT, KILLED})
    );

    // the queue only picks a free entry.
    a_enq_idle: assert property (
        @(posedge dcu_clk) disable iff (!dcu_reset_n)
        enq_valid |-> (fsm_state == INVALID)
    );

endmodule

// ==== logic/evb_pkg.sv ====
// types for one eviction buffer entry; func and probe codes are one-hot and never checked.
`include "evb_consts.svh"

package evb_pkg;

    typedef logic [`EVB_PALEN-1:0] evb_addr_t;

    typedef logic [3:0] evb_way_t; // one-hot.

    // line state bits.
    typedef logic [3:0] evb_line_state_t;
    localparam int unsigned S_BIT = 0;
    localparam int unsigned E_BIT = 1;
    localparam int unsigned M_BIT = 2;
    localparam int unsigned L_BIT = 3;

    // wb, wbinval, inval, cctl, acctl, probe from bit 0 up.
    typedef logic [5:0] evb_func_t;

    // ton, tob, tot, probe-block from bit 0 up.
    typedef logic [3:0] evb_probe_t;

    typedef logic [$clog2(`EVB_BEATS)-1:0] evb_beat_t;

    typedef logic [`EVB_DATA_W-1:0] evb_data_t;

    typedef logic [2:0] evb_opcode_t;

    typedef logic [2:0] evb_param_t;

    typedef logic [2:0] evb_mesi_t;

    typedef logic [`EVB_SOURCE_W-1:0] evb_source_t;

    typedef enum logic [2:0] {
        INVALID,
        SPECULATIVE,
        COMMITTED,
        RELEASE,
        INFLIGHT,
        KILLED
    } evb_fsm_e;

endpackage

// ==== logic/evb_consts.svh ====
// geometry is fixed to a 32 KB, 4-way cache with 64-byte lines and 128-bit beats.
`ifndef EVB_CONSTS_SVH
`define EVB_CONSTS_SVH

// physical address width.
`define EVB_PALEN 32

// one cache array beat.
`define EVB_DATA_W 128

// beats per 64-byte line.
`define EVB_BEATS 4

// set index, 128 sets of 4 ways.
`define EVB_IDX_LSB 6
`define EVB_IDX_MSB 12

// c-channel source id width.
`define EVB_SOURCE_W 2

`endif
